// File: list.f
+incdir+logic
+incdir+tests
logic/cache_pkg.sv
logic/direct_mapped_cache.sv
logic/mem_request_bridge.sv
logic/axi_single_beat_master.sv
logic/cache_axi_top.sv
tests/cache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cache_tb -f list.f -o cache_sim; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/cache_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
else
    exit 1
fi

// File: tests/cache_tests.svh
task automatic test_reset_and_hit();
    addr_t a;
    data_t d;
    bit    e;
    int    cyc;
    int    base;
    a = 32'h0000_0104;
    begin_test("reset_and_hit");
    check_flag("req_ack after reset", 1'b0, req_ack);
    check_flag("resp_valid after reset", 1'b0, resp_valid);
    check_flag("arvalid after reset", 1'b0, arvalid);
    check_flag("awvalid after reset", 1'b0, awvalid);
    check_flag("wvalid after reset", 1'b0, wvalid);
    check_flag("rready after reset", 1'b0, rready);
    check_flag("bready after reset", 1'b0, bready);
    base = ar_count;
    access(1'b0, a, '0, '0, d, e, cyc);
    check_data("miss data", mem_words[a[11:2]], d);
    check_flag("miss error", 1'b0, e);
    check_count("AR count after miss", base + 1, ar_count);
    access(1'b0, a, '0, '0, d, e, cyc);
    check_data("hit data", mem_words[a[11:2]], d);
    check_count("AR count after hit", base + 1, ar_count);
    check_count("hit latency", 2, cyc);
    end_test();
endtask

task automatic test_write_through_mask();
    addr_t a;
    data_t d;
    data_t expected;
    bit    e;
    int    cyc;
    int    base;
    a = 32'h0000_0104;
    begin_test("write_through_mask");
    // lanes 0 and 2 take the new bytes
    expected = (mem_words[a[11:2]] & 32'hFF00_FF00) | (32'hDEAD_BEEF & 32'h00FF_00FF);
    access(1'b1, a, 32'hDEAD_BEEF, 4'b0101, d, e, cyc);
    check_data("write response word", '0, d);
    check_flag("write error", 1'b0, e);
    check_data("memory after write", expected, mem_words[a[11:2]]);
    base = ar_count;
    access(1'b0, a, '0, '0, d, e, cyc);
    check_data("merged hit data", expected, d);
    check_count("AR count after hit", base, ar_count);
    end_test();
endtask

task automatic test_write_miss();
    addr_t a;
    data_t d;
    bit    e;
    int    cyc;
    int    base;
    a = 32'h0000_0208;
    begin_test("write_miss");
    access(1'b1, a, 32'h1234_5678, 4'hF, d, e, cyc);
    check_data("memory after write", 32'h1234_5678, mem_words[a[11:2]]);
    base = ar_count;
    access(1'b0, a, '0, '0, d, e, cyc);
    check_count("AR count after read", base + 1, ar_count);
    check_data("read data", 32'h1234_5678, d);
    end_test();
endtask

task automatic test_conflict_eviction();
    addr_t a;
    addr_t b;
    data_t d;
    bit    e;
    int    cyc;
    int    base;
    // same index but a different tag
    a = 32'h0000_0310;
    b = 32'h0000_0710;
    begin_test("conflict_eviction");
    base = ar_count;
    access(1'b0, a, '0, '0, d, e, cyc);
    check_data("first read of A", mem_words[a[11:2]], d);
    access(1'b0, b, '0, '0, d, e, cyc);
    check_data("read of B", mem_words[b[11:2]], d);
    access(1'b0, a, '0, '0, d, e, cyc);
    check_data("second read of A", mem_words[a[11:2]], d);
    check_count("AR count", base + 3, ar_count);
    end_test();
endtask

task automatic test_error_response();
    addr_t a;
    data_t d;
    bit    e;
    int    cyc;
    int    base;
    a = 32'hF000_0040;
    begin_test("error_response");
    base = ar_count;
    access(1'b0, a, '0, '0, d, e, cyc);
    check_flag("first read error", 1'b1, e);
    access(1'b0, a, '0, '0, d, e, cyc);
    check_flag("repeat read error", 1'b1, e);
    check_count("AR count", base + 2, ar_count);
    access(1'b1, a, 32'h0BAD_F00D, 4'hF, d, e, cyc);
    check_flag("write error", 1'b1, e);
    end_test();
endtask

task automatic test_back_pressure();
    addr_t a;
    addr_t b;
    data_t held;
    data_t d;
    bit    e;
    int    cyc;
    int    hold;
    a = 32'h0000_0104;
    b = 32'h0000_0208;
    hold = 3 + int'(xorshift32(32'd36) % 8);
    begin_test("back_pressure");
    start_request(1'b0, a, '0, '0);
    wait_req_ack(cyc);
    wait_response(cyc, held, e);
    check_data("held word", mem_words[a[11:2]], held);
    // second request waits behind the unacknowledged response
    start_request(1'b0, b, '0, '0);
    for (int i = 0; i < hold; i++)
    begin
        @(posedge clk_in);
        #1;
        check_flag("resp_valid held", 1'b1, resp_valid);
        check_data("resp_rdata held", held, resp_rdata);
        check_flag("no req_ack while stalled", 1'b0, req_ack);
    end
    ack_response();
    wait_req_ack(cyc);
    wait_response(cyc, d, e);
    check_data("second read data", mem_words[b[11:2]], d);
    ack_response();
    end_test();
endtask

// File: tests/cache_tb.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_tb
    import cache_pkg::*;
();

    localparam int num_tests       = 6;
    localparam int cycles_per_test = 200;
    localparam int wait_limit      = 100;
    localparam int mem_depth       = 1024;

    logic      clk_in;
    logic      reset_in;
    logic      req_valid;
    logic      req_write;
    addr_t     req_addr;
    data_t     req_wdata;
    mask_t     req_mask;
    logic      resp_ack;
    logic      req_ack;
    logic      resp_valid;
    data_t     resp_rdata;
    logic      resp_error;
    logic      awready;
    logic      wready;
    logic      bvalid;
    axi_resp_t bresp;
    logic      arready;
    logic      rvalid;
    data_t     rdata;
    axi_resp_t rresp;
    logic      awvalid;
    addr_t     awaddr;
    logic      wvalid;
    data_t     wdata;
    mask_t     wstrb;
    logic      bready;
    logic      arvalid;
    addr_t     araddr;
    logic      rready;

    data_t       mem_words [mem_depth];
    int          ar_count;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          errors_at_start;
    string       test_name;

    cache_axi_top u_cache_axi_top (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // used by the memory model only
    function int random_below(input int limit);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % limit);
    endfunction

    function automatic data_t fill_word(input int word_index);
        return (data_t'(word_index) * 32'h9E37_79B9) ^ 32'hC3A5_0000;
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input mask_t mask);
        data_t result;
        result = old_word;
        for (int i = 0; i < `CACHE_MASK_WIDTH; i++)
        begin
            if (mask[i])
            begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic bit in_error_range(input addr_t addr);
        return addr >= 32'hF000_0000;
    endfunction

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    initial
    begin
        #((num_tests * cycles_per_test + 20) * 10);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    // AXI slave sampled and driven 1 ns after each rising edge
    initial
    begin : axi_memory_model
        logic  ar_hs, r_hs, aw_hs, w_hs, b_hs;
        logic  aw_got, w_got, r_pending, b_pending;
        addr_t ar_addr, aw_addr;
        data_t w_data;
        mask_t w_strb;
        int    ar_delay, aw_delay, w_delay, r_delay, b_delay;
        {arready, rvalid, awready, wready, bvalid} = '0;
        rdata = '0;
        rresp = '0;
        bresp = '0;
        {ar_hs, r_hs, aw_hs, w_hs, b_hs, aw_got, w_got, r_pending, b_pending} = '0;
        {ar_addr, aw_addr, w_data, w_strb} = '0;
        {ar_delay, aw_delay, w_delay, r_delay, b_delay} = '0;
        rng_state = 32'd36;
        ar_count = 0;
        for (int i = 0; i < mem_depth; i++)
        begin
            mem_words[i] = fill_word(i);
        end
        forever
        begin
            @(posedge clk_in);
            #1;
            // handshakes that completed on this edge
            if (ar_hs)
            begin
                ar_count++;
                r_pending = 1'b1;
                r_delay = random_below(4);
                ar_delay = random_below(4);
            end
            if (r_hs)
            begin
                rvalid = 1'b0;
            end
            if (aw_hs)
            begin
                aw_got = 1'b1;
                aw_delay = random_below(4);
            end
            if (w_hs)
            begin
                w_got = 1'b1;
                w_delay = random_below(4);
            end
            if (b_hs)
            begin
                bvalid = 1'b0;
            end
            if (aw_got && w_got)
            begin
                if (!in_error_range(aw_addr))
                begin
                    mem_words[aw_addr[11:2]] = merge_bytes(mem_words[aw_addr[11:2]], w_data,
                                                           w_strb);
                end
                aw_got = 1'b0;
                w_got = 1'b0;
                b_pending = 1'b1;
                b_delay = random_below(4);
            end
            {arready, awready, wready} = '0;
            if (arvalid)
            begin
                if (ar_delay == 0)
                    arready = 1'b1;
                else
                    ar_delay--;
            end
            if (awvalid)
            begin
                if (aw_delay == 0)
                    awready = 1'b1;
                else
                    aw_delay--;
            end
            if (wvalid)
            begin
                if (w_delay == 0)
                    wready = 1'b1;
                else
                    w_delay--;
            end
            if (r_pending)
            begin
                if (r_delay == 0)
                begin
                    rvalid = 1'b1;
                    rdata = in_error_range(ar_addr) ? '0 : mem_words[ar_addr[11:2]];
                    rresp = in_error_range(ar_addr) ? 2'b10 : 2'b00;
                    r_pending = 1'b0;
                end
                else
                begin
                    r_delay--;
                end
            end
            if (b_pending)
            begin
                if (b_delay == 0)
                begin
                    bvalid = 1'b1;
                    bresp = in_error_range(aw_addr) ? 2'b10 : 2'b00;
                    b_pending = 1'b0;
                end
                else
                begin
                    b_delay--;
                end
            end
            // what the DUT will see on the next edge
            ar_hs = arvalid && arready;
            if (ar_hs)
                ar_addr = araddr;
            aw_hs = awvalid && awready;
            if (aw_hs)
                aw_addr = awaddr;
            w_hs = wvalid && wready;
            if (w_hs)
            begin
                w_data = wdata;
                w_strb = wstrb;
            end
            r_hs = rvalid && rready;
            b_hs = bvalid && bready;
        end
    end

    task automatic check_data(input string what, input data_t expected, input data_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input bit expected, input bit actual);
        checks++;
        if (actual != expected)
        begin
            errors++;
            $display("Fail %s %s: expected %0b, actual %0b", test_name, what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        checks++;
        if (actual != expected)
        begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
    endtask

    // every client task enters and leaves 1 ns after a rising edge
    task automatic start_request(input logic write, input addr_t addr, input data_t wdata,
                                 input mask_t mask);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_mask  = mask;
    endtask

    task automatic wait_req_ack(output int cycles);
        cycles = 0;
        while (!req_ack && cycles < wait_limit)
        begin
            @(posedge clk_in);
            #1;
            cycles++;
        end
        if (!req_ack)
        begin
            errors++;
            $display("test %s: request was never acknowledged", test_name);
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_response(inout int cycles, output data_t data, output bit error);
        int n;
        n = 0;
        while (!resp_valid && n < wait_limit)
        begin
            @(posedge clk_in);
            #1;
            n++;
        end
        cycles = cycles + n;
        if (!resp_valid)
        begin
            errors++;
            $display("test %s: no response from the cache", test_name);
        end
        data  = resp_rdata;
        error = resp_error;
    endtask

    task automatic ack_response();
        resp_ack = 1'b1;
        @(posedge clk_in);
        #1;
        resp_ack = 1'b0;
    endtask

    task automatic access(input logic write, input addr_t addr, input data_t wdata,
                          input mask_t mask, output data_t data, output bit error,
                          output int cycles);
        start_request(write, addr, wdata, mask);
        wait_req_ack(cycles);
        wait_response(cycles, data, error);
        ack_response();
    endtask

    `include "cache_tests.svh"

    initial
    begin
        reset_in  = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_mask  = '0;
        resp_ack  = 1'b0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        repeat (5) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        test_reset_and_hit();
        test_write_through_mask();
        test_write_miss();
        test_conflict_eviction();
        test_error_response();
        test_back_pressure();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: logic/cache_axi_top.sv
`timescale 1ns/1ns

module cache_axi_top
    import cache_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,
    input  logic      req_valid,
    input  logic      req_write,
    input  addr_t     req_addr,
    input  data_t     req_wdata,
    input  mask_t     req_mask,
    input  logic      resp_ack,
    output logic      req_ack,
    output logic      resp_valid,
    output data_t     resp_rdata,
    output logic      resp_error,
    input  logic      awready,
    input  logic      wready,
    input  logic      bvalid,
    input  axi_resp_t bresp,
    input  logic      arready,
    input  logic      rvalid,
    input  data_t     rdata,
    input  axi_resp_t rresp,
    output logic      awvalid,
    output addr_t     awaddr,
    output logic      wvalid,
    output data_t     wdata,
    output mask_t     wstrb,
    output logic      bready,
    output logic      arvalid,
    output addr_t     araddr,
    output logic      rready
);

    logic      mem_req_valid;
    logic      mem_req_write;
    addr_t     mem_req_addr;
    data_t     mem_req_wdata;
    mask_t     mem_req_mask;
    logic      mem_ack;
    data_t     mem_rdata;
    logic      mem_error;
    logic      txn_start;
    logic      txn_done;
    data_t     txn_rdata;
    axi_resp_t txn_resp;

    direct_mapped_cache u_cache
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_mask      (req_mask),
        .resp_ack      (resp_ack),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .mem_error     (mem_error),
        .req_ack       (req_ack),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_error    (resp_error),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_mask  (mem_req_mask)
    );

    mem_request_bridge u_bridge
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .mem_req_valid (mem_req_valid),
        .txn_done      (txn_done),
        .txn_rdata     (txn_rdata),
        .txn_resp      (txn_resp),
        .txn_start     (txn_start),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .mem_error     (mem_error)
    );

    // request fields go straight from the cache to the master
    axi_single_beat_master u_master
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .txn_start (txn_start),
        .txn_write (mem_req_write),
        .txn_addr  (mem_req_addr),
        .txn_wdata (mem_req_wdata),
        .txn_mask  (mem_req_mask),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .txn_done  (txn_done),
        .txn_rdata (txn_rdata),
        .txn_resp  (txn_resp),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bready    (bready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .rready    (rready)
    );

endmodule

// File: logic/axi_single_beat_master.sv
`timescale 1ns/1ns

module axi_single_beat_master
    import cache_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,
    input  logic      txn_start,
    input  logic      txn_write,
    input  addr_t     txn_addr,
    input  data_t     txn_wdata,
    input  mask_t     txn_mask,
    input  logic      awready,
    input  logic      wready,
    input  logic      bvalid,
    input  axi_resp_t bresp,
    input  logic      arready,
    input  logic      rvalid,
    input  data_t     rdata,
    input  axi_resp_t rresp,
    output logic      txn_done,
    output data_t     txn_rdata,
    output axi_resp_t txn_resp,
    output logic      awvalid,
    output addr_t     awaddr,
    output logic      wvalid,
    output data_t     wdata,
    output mask_t     wstrb,
    output logic      bready,
    output logic      arvalid,
    output addr_t     araddr,
    output logic      rready
);

    axi_state_t state;
    logic       aw_done;
    logic       w_done;

    // channel finished already or handshaking now
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state     <= axi_idle;
            txn_done  <= 1'b0;
            txn_rdata <= '0;
            txn_resp  <= '0;
            awvalid   <= 1'b0;
            awaddr    <= '0;
            wvalid    <= 1'b0;
            wdata     <= '0;
            wstrb     <= '0;
            bready    <= 1'b0;
            arvalid   <= 1'b0;
            araddr    <= '0;
            rready    <= 1'b0;
        end
        else
        begin
            txn_done <= 1'b0;
            case (state)
                axi_idle:
                begin
                    if (txn_start && txn_write)
                    begin
                        awvalid <= 1'b1;
                        awaddr  <= txn_addr;
                        wvalid  <= 1'b1;
                        wdata   <= txn_wdata;
                        wstrb   <= txn_mask;
                        state   <= axi_write_req;
                    end
                    else if (txn_start)
                    begin
                        arvalid <= 1'b1;
                        araddr  <= txn_addr;
                        state   <= axi_read_addr;
                    end
                end
                axi_read_addr:
                begin
                    if (arready)
                    begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= axi_read_data;
                    end
                end
                axi_read_data:
                begin
                    if (rvalid)
                    begin
                        rready    <= 1'b0;
                        txn_rdata <= rdata;
                        txn_resp  <= rresp;
                        txn_done  <= 1'b1;
                        state     <= axi_idle;
                    end
                end
                axi_write_req:
                begin
                    if (awready)
                    begin
                        awvalid <= 1'b0;
                    end
                    if (wready)
                    begin
                        wvalid <= 1'b0;
                    end
                    if (aw_done && w_done)
                    begin
                        bready <= 1'b1;
                        state  <= axi_write_resp;
                    end
                end
                default:
                begin
                    if (bvalid)
                    begin
                        bready    <= 1'b0;
                        txn_rdata <= '0;
                        txn_resp  <= bresp;
                        txn_done  <= 1'b1;
                        state     <= axi_idle;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        awvalid && !awready |=> $stable(awaddr));

endmodule

// File: logic/mem_request_bridge.sv
`timescale 1ns/1ns

module mem_request_bridge
    import cache_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,
    input  logic      mem_req_valid,
    input  logic      txn_done,
    input  data_t     txn_rdata,
    input  axi_resp_t txn_resp,
    output logic      txn_start,
    output logic      mem_ack,
    output data_t     mem_rdata,
    output logic      mem_error
);

    logic mem_req_valid_q;
    logic busy;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            mem_req_valid_q <= 1'b0;
            txn_start       <= 1'b0;
            mem_ack         <= 1'b0;
            busy            <= 1'b0;
        end
        else
        begin
            mem_req_valid_q <= mem_req_valid;

            // one start per rising edge of the request level
            txn_start <= mem_req_valid && !mem_req_valid_q;

            mem_ack <= txn_done;

            if (txn_start)
            begin
                busy <= 1'b1;
            end
            else if (txn_done)
            begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (txn_done)
        begin
            mem_rdata <= txn_rdata;
            // slverr and decerr both have the upper bit set
            mem_error <= txn_resp[1];
        end
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        txn_start |-> !busy);

endmodule

// File: logic/direct_mapped_cache.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module direct_mapped_cache
    import cache_pkg::*;
(
    input  logic  clk_in,
    input  logic  reset_in,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  data_t req_wdata,
    input  mask_t req_mask,
    input  logic  resp_ack,
    input  logic  mem_ack,
    input  data_t mem_rdata,
    input  logic  mem_error,
    output logic  req_ack,
    output logic  resp_valid,
    output data_t resp_rdata,
    output logic  resp_error,
    output logic  mem_req_valid,
    output logic  mem_req_write,
    output addr_t mem_req_addr,
    output data_t mem_req_wdata,
    output mask_t mem_req_mask
);

    localparam int offset_bits = $clog2(`CACHE_MASK_WIDTH);
    localparam int index_bits  = $bits(index_t);
    localparam int tag_bits    = $bits(tag_t);

    cache_state_t               state;
    logic [`CACHE_NUM_SETS-1:0] valid_bits;
    tag_t                       tag_array  [`CACHE_NUM_SETS];
    data_t                      data_array [`CACHE_NUM_SETS];

    index_t line_index;
    tag_t   line_tag;
    logic   hit;
    logic   fill_en;
    logic   merge_en;
    data_t  merged_word;

    // the held memory request doubles as the captured client request
    assign line_index = mem_req_addr[offset_bits +: index_bits];
    assign line_tag   = mem_req_addr[`CACHE_ADDR_WIDTH-1 -: tag_bits];
    assign hit        = valid_bits[line_index] && (tag_array[line_index] == line_tag);

    assign fill_en  = (state == cache_fill_wait) && mem_ack && !mem_error;
    assign merge_en = (state == cache_write_wait) && mem_ack && !mem_error && hit;

    // byte merge for write hits
    always_comb
    begin
        merged_word = data_array[line_index];
        for (int i = 0; i < `CACHE_MASK_WIDTH; i++)
        begin
            if (mem_req_mask[i])
            begin
                merged_word[8*i +: 8] = mem_req_wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (state == cache_idle && req_valid)
        begin
            mem_req_write <= req_write;
            mem_req_addr  <= req_addr;
            mem_req_wdata <= req_wdata;
            mem_req_mask  <= req_mask;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (fill_en)
        begin
            tag_array[line_index]  <= line_tag;
            data_array[line_index] <= mem_rdata;
        end
        else if (merge_en)
        begin
            data_array[line_index] <= merged_word;
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state         <= cache_idle;
            valid_bits    <= '0;
            req_ack       <= 1'b0;
            resp_valid    <= 1'b0;
            resp_rdata    <= '0;
            resp_error    <= 1'b0;
            mem_req_valid <= 1'b0;
        end
        else
        begin
            req_ack <= 1'b0;
            case (state)
                cache_idle:
                begin
                    if (req_valid)
                    begin
                        state <= cache_lookup;
                    end
                end
                cache_lookup:
                begin
                    req_ack <= 1'b1;
                    if (mem_req_write || !hit)
                    begin
                        mem_req_valid <= 1'b1;
                        state         <= mem_req_write ? cache_write_wait : cache_fill_wait;
                    end
                    else
                    begin
                        resp_valid <= 1'b1;
                        resp_rdata <= data_array[line_index];
                        resp_error <= 1'b0;
                        state      <= cache_respond;
                    end
                end
                cache_fill_wait, cache_write_wait:
                begin
                    if (mem_ack)
                    begin
                        if (fill_en)
                        begin
                            valid_bits[line_index] <= 1'b1;
                        end
                        mem_req_valid <= 1'b0;
                        resp_valid    <= 1'b1;
                        // writes return a zero word
                        resp_rdata    <= (state == cache_fill_wait) ? mem_rdata : '0;
                        resp_error    <= mem_error;
                        state         <= cache_respond;
                    end
                end
                default:
                begin
                    if (resp_ack)
                    begin
                        resp_valid <= 1'b0;
                        state      <= cache_idle;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        mem_req_valid && !mem_ack |=> mem_req_valid);

    assert property (@(posedge clk_in) disable iff (reset_in)
        resp_valid && !resp_ack |=> resp_valid && $stable(resp_rdata));

endmodule

// File: logic/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`CACHE_DATA_WIDTH-1:0] data_t;
    typedef logic [`CACHE_MASK_WIDTH-1:0] mask_t;
    typedef logic [$clog2(`CACHE_NUM_SETS)-1:0] index_t;

    // address bits above index and byte offset
    typedef logic [`CACHE_ADDR_WIDTH - $clog2(`CACHE_NUM_SETS)
                   - $clog2(`CACHE_MASK_WIDTH) - 1:0] tag_t;

    // okay, exokay, slverr, decerr
    typedef logic [1:0] axi_resp_t;

    typedef enum logic [2:0]
    {
        cache_idle,
        cache_lookup,
        cache_fill_wait,
        cache_write_wait,
        cache_respond
    } cache_state_t;

    typedef enum logic [2:0]
    {
        axi_idle,
        axi_read_addr,
        axi_read_data,
        axi_write_req,
        axi_write_resp
    } axi_state_t;

endpackage

// File: logic/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address width
`define CACHE_ADDR_WIDTH 32

// one bus word per line
`define CACHE_DATA_WIDTH 32

// sets equal lines when direct mapped
`define CACHE_NUM_SETS 16

`define CACHE_MASK_WIDTH (`CACHE_DATA_WIDTH / 8)

`endif
